//--- Makefile
TOP = tb_video_post

all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build lint clean

//--- dv/tb_video_tests.svh
// two clocks in reset and a few idle clocks after release
task automatic verify_reset();
    string name = "reset_state";
    for (int i = 0; i < 5; i++)
    begin
        @(negedge o_post_clk);
        if (o_post_vs !== 1'b1)
            report_mismatch(name, "o_post_vs", 32'd1, 32'(o_post_vs));
        if (o_post_de !== 1'b0)
            report_mismatch(name, "o_post_de", 32'd0, 32'(o_post_de));
        if (o_disp.sync.de !== 1'b0)
            report_mismatch(name, "o_disp.de", 32'd0, 32'(o_disp.sync.de));
        if (o_post_camvs !== 1'b0)
            report_mismatch(name, "o_post_camvs", 32'd0, 32'(o_post_camvs));
        if (i == 1)
            rst_n = 1'b1;
    end
    close_test(name);
endtask

// stops on the first clock with o_post_vs low after a high one
task automatic wait_vs_fall(string name);
    logic prev_vs;
    int   n;
    @(negedge o_post_clk);
    prev_vs = o_post_vs;
    @(negedge o_post_clk);
    n = 1;
    while (!(prev_vs && !o_post_vs) && n < 2 * FRAME_CYC)
    begin
        prev_vs = o_post_vs;
        @(negedge o_post_clk);
        n++;
    end
    if (n >= 2 * FRAME_CYC)
        report_failure(name, "o_post_vs never fell");
endtask

task automatic measure_frame_timing();
    string name = "frame_timing";
    sync_t exp;
    logic  prev_vs;
    int    period;
    int    de_cnt;
    int    low_cnt;
    wait_vs_fall(name);
    period  = 0;
    de_cnt  = 0;
    low_cnt = 0;
    do
    begin
        exp = exp_post_sync(cyc_cnt);
        if ({o_post_vs, o_post_de} !== {exp.vs, exp.de})
            report_mismatch(name, "vs,de", 32'({exp.vs, exp.de}), 32'({o_post_vs, o_post_de}));
        if (o_post_de)
            de_cnt++;
        if (!o_post_vs)
            low_cnt++;
        prev_vs = o_post_vs;
        @(negedge o_post_clk);
        period++;
    end
    while (!(prev_vs && !o_post_vs) && period < 2 * FRAME_CYC);
    if (period != FRAME_CYC)
        report_mismatch(name, "frame period", 32'(FRAME_CYC), 32'(period));
    if (de_cnt != H_ACTIVE * V_ACTIVE)
        report_mismatch(name, "de clocks", 32'(H_ACTIVE * V_ACTIVE), 32'(de_cnt));
    if (low_cnt != V_SYNC * H_TOTAL)
        report_mismatch(name, "vs low clocks", 32'(V_SYNC * H_TOTAL), 32'(low_cnt));
    close_test(name);
endtask

task automatic gate_fb_pixels();
    string       name = "fb_gating";
    logic [31:0] rnd;
    rgb565_t     exp;
    for (int i = 0; i < 48; i++)
    begin
        rnd      = $random(seed);
        i_fb_pix = rnd[16:0];
        @(negedge o_post_clk);
        if (i_fb_pix.valid)
            exp = i_fb_pix.data;
        else
            exp = '0;   // invalid words read as black
        if (o_post_data !== exp)
            report_mismatch(name, "o_post_data", 32'(exp), 32'(o_post_data));
    end
    i_fb_pix = '0;
    close_test(name);
endtask

task automatic align_display();
    string       name = "display_align";
    sync_t       hist [FRAME_CYC + OUT_DELAY];
    sync_t       exp;
    rgb565_t     drv;
    logic [31:0] rnd;
    logic [23:0] exp_rgb;
    drv = i_post_data;
    for (int i = 0; i < FRAME_CYC + OUT_DELAY; i++)
    begin
        hist[i] = exp_post_sync(cyc_cnt);   // expected o_post sync
        if (i >= OUT_DELAY)
        begin
            exp = hist[i - OUT_DELAY];
            if (o_disp.sync !== exp)
                report_mismatch(name, "disp sync", 32'(exp), 32'(o_disp.sync));
            exp_rgb = exp.de ? expand_565(drv) : 24'h0;
            if ({o_disp.r, o_disp.g, o_disp.b} !== exp_rgb)
                report_mismatch(name, "disp rgb", 32'(exp_rgb),
                                32'({o_disp.r, o_disp.g, o_disp.b}));
        end
        rnd         = $random(seed);
        drv         = rnd[15:0];
        i_post_data = drv;
        @(negedge o_post_clk);
    end
    close_test(name);
endtask

// pulses i_finish in active video and follows camvs over one frame
task automatic handshake_round(string name);
    int phase;
    int high_cnt;
    int n;
    n = 0;
    while (!o_post_de && n < FRAME_CYC)
    begin
        @(negedge o_post_clk);
        n++;
    end
    i_finish = 1'b1;
    @(negedge o_post_clk);
    i_finish = 1'b0;
    phase    = 0;
    high_cnt = 0;
    n        = 0;
    while (phase < 3 && n < 3 * FRAME_CYC)
    begin
        if (o_post_camvs !== (phase != 0))
            report_mismatch(name, "o_post_camvs", 32'(phase != 0), 32'(o_post_camvs));
        if (phase != 0)
            high_cnt++;
        case (phase)
            0: if (!o_post_vs) phase = 1;         // rises on the next edge
            1: if (o_post_vs) phase = 2;
            default: if (!o_post_vs) phase = 3;   // falls on the next edge
        endcase
        @(negedge o_post_clk);
        n++;
    end
    if (phase != 3)
        report_failure(name, "o_post_camvs did not rise and fall around one frame");
    else if (o_post_camvs !== 1'b0)
        report_mismatch(name, "o_post_camvs after fall", 32'd0, 32'(o_post_camvs));
    if (high_cnt != FRAME_CYC)
        report_mismatch(name, "camvs high clocks", 32'(FRAME_CYC), 32'(high_cnt));
endtask

task automatic run_handshake();
    string name = "frame_handshake";
    handshake_round(name);
    handshake_round(name);
    for (int i = 0; i < FRAME_CYC; i++)
    begin
        if (o_post_camvs !== 1'b0)
            report_mismatch(name, "camvs without finish", 32'd0, 32'(o_post_camvs));
        @(negedge o_post_clk);
    end
    close_test(name);
endtask

//--- dv/tb_video_post.sv
`timescale 1ns/1ns

module tb_video_post
    import video_pkg::*;
();

    localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;
    // frame timing 2 frames, alignment 1, handshake up to 7, rest is slack
    localparam int WATCHDOG_CYC = 12 * FRAME_CYC;

    logic    o_post_clk = 1'b0;
    logic    rst_n;
    logic    i_finish;
    fb_pix_t i_fb_pix;
    rgb565_t i_post_data;
    logic    o_post_vs;
    logic    o_post_de;
    rgb565_t o_post_data;
    disp_t   o_disp;
    logic    o_post_camvs;

    int seed = 32'ha28f;
    int cyc_cnt;   // clocks since reset release
    int test_errs;
    int pass_cnt;
    int fail_cnt;

    always #10 o_post_clk = ~o_post_clk;

    video_post_top dut_i (
        .o_post_clk   (o_post_clk),
        .rst_n        (rst_n),
        .i_finish     (i_finish),
        .i_fb_pix     (i_fb_pix),
        .i_post_data  (i_post_data),
        .o_post_vs    (o_post_vs),
        .o_post_de    (o_post_de),
        .o_post_data  (o_post_data),
        .o_disp       (o_disp),
        .o_post_camvs (o_post_camvs)
    );

    always @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
            cyc_cnt <= 0;
        else
            cyc_cnt <= cyc_cnt + 1;
    end

    // expected o_post sync k clocks after reset release
    function automatic sync_t exp_post_sync(int k);
        sync_t s;
        int    p;
        int    h;
        int    v;
        s = SYNC_IDLE;
        if (k > IN_DELAY)
        begin
            p = (k - 1 - IN_DELAY) % FRAME_CYC;   // counter position it came from
            h = p % H_TOTAL;
            v = p / H_TOTAL;
            s.de = (h < H_ACTIVE) && (v < V_ACTIVE);
            s.hs = !((h >= H_ACTIVE + H_FP) && (h < H_ACTIVE + H_FP + H_SYNC));
            s.vs = !((v >= V_ACTIVE + V_FP) && (v < V_ACTIVE + V_FP + V_SYNC));
        end
        return s;
    endfunction

    function automatic logic [23:0] expand_565(rgb565_t p);
        return {p.r, 3'b000, p.g, 2'b00, p.b, 3'b000};
    endfunction

    task automatic report_mismatch(string test, string what,
                                   logic [31:0] exp, logic [31:0] act);
        $display("ERR %s %s expected %0h actual %0h at %0t", test, what, exp, act, $time);
        test_errs++;
    endtask

    task automatic report_failure(string test, string msg);
        $display("%s failed at %0t: %s", test, $time, msg);
        test_errs++;
    endtask

    task automatic close_test(string name);
        if (test_errs == 0)
        begin
            pass_cnt++;
            $display("pass  %s", name);
        end
        else
        begin
            fail_cnt++;
            $display("fail  %s, %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    `include "tb_video_tests.svh"

    initial
    begin
        rst_n       = 1'b0;
        i_finish    = 1'b0;
        i_fb_pix    = '0;
        i_post_data = '0;
        verify_reset();
        measure_frame_timing();
        gate_fb_pixels();
        align_display();
        run_handshake();
        $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge o_post_clk);
        $display("watchdog: tests did not finish within %0d clocks", WATCHDOG_CYC);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- logic/frame_handshake.sv
`timescale 1ns/1ns

module frame_handshake (
    input  logic o_post_clk,
    input  logic rst_n,
    input  logic i_finish,
    input  logic i_post_vs,
    output logic o_post_camvs
);

    typedef enum logic [3:0] {
        ST_WAIT_VS_LOW   = 4'b0001,
        ST_WAIT_VS_HIGH  = 4'b0010,
        ST_WAIT_VS_LOW2  = 4'b0100,
        ST_WAIT_FINISH   = 4'b1000
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb
    begin
        state_nxt = state;
        unique case (state)
            ST_WAIT_FINISH:
                if (i_finish)
                    state_nxt = ST_WAIT_VS_LOW;
            ST_WAIT_VS_LOW:
                if (!i_post_vs)
                    state_nxt = ST_WAIT_VS_HIGH;   // start of the camera frame
            ST_WAIT_VS_HIGH:
                if (i_post_vs)
                    state_nxt = ST_WAIT_VS_LOW2;
            ST_WAIT_VS_LOW2:
                if (!i_post_vs)
                    state_nxt = ST_WAIT_FINISH;
            default:
                state_nxt = ST_WAIT_FINISH;
        endcase
    end

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_WAIT_FINISH;
        else
            state <= state_nxt;
    end

    // high for exactly one display frame
    assign o_post_camvs = (state == ST_WAIT_VS_HIGH) || (state == ST_WAIT_VS_LOW2);

    a_state_onehot: assert property (
        @(posedge o_post_clk) disable iff (!rst_n)
        $onehot(state)
    );

endmodule

//--- logic/pixel_path.sv
`timescale 1ns/1ns

module pixel_path
    import video_pkg::*;
(
    input  logic    o_post_clk,
    input  logic    rst_n,
    input  fb_pix_t i_fb_pix,
    input  rgb565_t i_post_data,
    input  sync_t   i_disp_sync,
    output rgb565_t o_post_data,
    output disp_t   o_disp
);

    rgb565_t pix_q;

    // invalid frame buffer words go out as black
    assign o_post_data = i_fb_pix.valid ? i_fb_pix.data : '0;

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
            pix_q <= '0;
        else
            pix_q <= i_post_data;
    end

    always_comb
    begin
        o_disp.sync = i_disp_sync;
        if (i_disp_sync.de)
        begin
            // 565 to 888, zeros below
            o_disp.r = {pix_q.r, 3'b000};
            o_disp.g = {pix_q.g, 2'b00};
            o_disp.b = {pix_q.b, 3'b000};
        end
        else
        begin
            o_disp.r = '0;   // blanking
            o_disp.g = '0;
            o_disp.b = '0;
        end
    end

endmodule

//--- logic/sync_delay_line.sv
`timescale 1ns/1ns

module sync_delay_line #(
    parameter type T         = logic,
    parameter int  DEPTH     = 2,
    parameter T    RESET_VAL = '0
)(
    input  logic o_post_clk,
    input  logic rst_n,
    input  T     i_data,
    output T     o_data
);

    T taps [DEPTH];

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
                taps[i] <= RESET_VAL;
        end
        else
        begin
            taps[0] <= i_data;
            for (int i = 1; i < DEPTH; i++)
                taps[i] <= taps[i - 1];
        end
    end

    assign o_data = taps[DEPTH - 1];   // DEPTH cycles late

    // shorter chains would be a plain register
    a_min_depth: assert property (
        @(posedge o_post_clk) DEPTH >= 2
    );

endmodule

//--- logic/video_pkg.sv
package video_pkg;

    // reduced frame, order per line is active, front porch, sync, back porch
    localparam int H_ACTIVE = 16;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 3;
    localparam int H_BP     = 3;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

    localparam int V_ACTIVE = 4;   // lines
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam int H_CNT_W  = $clog2(H_TOTAL);
    localparam int V_CNT_W  = $clog2(V_TOTAL);

    // raw sync to o_post, then o_post to display
    localparam int IN_DELAY    = 5;
    localparam int OUT_DELAY   = 11;
    localparam int TOTAL_DELAY = IN_DELAY + OUT_DELAY;

    typedef struct packed {
        logic hs;   // active low
        logic vs;   // active low
        logic de;
    } sync_t;

    localparam sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, de: 1'b0};

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic    valid;
        rgb565_t data;
    } fb_pix_t;

    typedef struct packed {
        sync_t      sync;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } disp_t;

endpackage

//--- logic/video_post_top.sv
`timescale 1ns/1ns

module video_post_top
    import video_pkg::*;
(
    input  logic    o_post_clk,
    input  logic    rst_n,
    input  logic    i_finish,
    input  fb_pix_t i_fb_pix,
    input  rgb565_t i_post_data,
    output logic    o_post_vs,
    output logic    o_post_de,
    output rgb565_t o_post_data,
    output disp_t   o_disp,
    output logic    o_post_camvs
);

    sync_t raw_sync;
    sync_t post_sync;
    sync_t disp_sync;

    video_timing_gen timing_i (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .o_sync     (raw_sync)
    );

    // aligns sync with the processed pixels
    sync_delay_line #(.T(sync_t), .DEPTH(IN_DELAY), .RESET_VAL(SYNC_IDLE)) post_dly_i (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_data     (raw_sync),
        .o_data     (post_sync)
    );

    assign o_post_vs = post_sync.vs;
    assign o_post_de = post_sync.de;

    // further delay up to the display
    sync_delay_line #(.T(sync_t), .DEPTH(OUT_DELAY), .RESET_VAL(SYNC_IDLE)) disp_dly_i (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .i_data     (post_sync),
        .o_data     (disp_sync)
    );

    pixel_path pixel_i (
        .o_post_clk  (o_post_clk),
        .rst_n       (rst_n),
        .i_fb_pix    (i_fb_pix),
        .i_post_data (i_post_data),
        .i_disp_sync (disp_sync),
        .o_post_data (o_post_data),
        .o_disp      (o_disp)
    );

    frame_handshake handshake_i (
        .o_post_clk   (o_post_clk),
        .rst_n        (rst_n),
        .i_finish     (i_finish),
        .i_post_vs    (post_sync.vs),
        .o_post_camvs (o_post_camvs)
    );

endmodule

//--- logic/video_timing_gen.sv
`timescale 1ns/1ns

module video_timing_gen
    import video_pkg::*;
(
    input  logic  o_post_clk,
    input  logic  rst_n,
    output sync_t o_sync
);

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    sync_t              sync_nxt;

    assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));

    // counters start on the first active pixel of line 0
    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else
        begin
            if (h_last)
            begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
            else
            begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    always_comb
    begin
        sync_nxt.de = (h_cnt < H_CNT_W'(H_ACTIVE)) && (v_cnt < V_CNT_W'(V_ACTIVE));
        sync_nxt.hs = !((h_cnt >= H_CNT_W'(H_ACTIVE + H_FP)) &&
                        (h_cnt <  H_CNT_W'(H_ACTIVE + H_FP + H_SYNC)));
        sync_nxt.vs = !((v_cnt >= V_CNT_W'(V_ACTIVE + V_FP)) &&
                        (v_cnt <  V_CNT_W'(V_ACTIVE + V_FP + V_SYNC)));
    end

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
            o_sync <= SYNC_IDLE;
        else
            o_sync <= sync_nxt;   // one cycle behind the counters
    end

    // no active pixels inside the vertical sync
    a_de_outside_vs: assert property (
        @(posedge o_post_clk) disable iff (!rst_n)
        o_sync.de |-> o_sync.vs
    );

endmodule

//--- sources.f
+incdir+dv
logic/video_pkg.sv
logic/video_timing_gen.sv
logic/sync_delay_line.sv
logic/pixel_path.sv
logic/frame_handshake.sv
logic/video_post_top.sv
dv/tb_video_post.sv
